//--- flist.f
+incdir+.
icache_pkg.sv
register_file_1r_1w.sv
ram_ws_rs_data_scm.sv
icache_tag_ram.sv
icache_ctrl.sv
icache_bank.sv
icache_bank_props.sv
tb_icache_bank.sv

//--- tb_icache_bank.sv
// Testbench for the cache bank with LFSR stimulus, reference model, check task and timeout
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module tb_icache_bank;

    import icache_pkg::*;

    localparam int num_random     = 2000;
    localparam int timeout_cycles = 3 * num_random + 64;

    logic      clk = 1'b0;
    logic      arst_n;
    logic      req_valid;
    req_t      req;
    logic      resp_valid;
    resp_t     resp;

    // Reference model state
    logic [`ICACHE_SETS-1:0] model_valid;
    tag_t                    model_tag [`ICACHE_SETS];
    line_t                   model_line [`ICACHE_SETS];

    // Expected responses for the following cycle
    resp_t       exp_q [$];
    string       test_name;
    logic [31:0] lfsr_state = 32'h662a;
    int          cycle_count = 0;

    icache_bank UUT (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .req_valid  ( req_valid  ),
        .req        ( req        ),
        .resp_valid ( resp_valid ),
        .resp       ( resp       )
    );

    always #4 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the test did not end within %0d cycles", timeout_cycles);
            $display("sim failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // Bound timing assertions, looked at away from the rising edge
    always @(negedge clk) begin
        if (UUT.props.fail_count != 0) begin
            $display("A response timing assertion on the bank failed");
            $display("sim failed");
            $fatal(1, "assertion failure");
        end
    end

    // Galois step, right-shift form
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hB4BCD35C;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r[i] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
        return r;
    endfunction

    function automatic logic [`ICACHE_ADDR_W-1:0] make_addr(input tag_t tg, input index_t idx,
                                                          input logic [3:0] off);
        return {tg, idx, off};
    endfunction

    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
            $display("sim failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Compare the stage-1 response against last cycle's expectation
    task automatic check_response();
        resp_t exp;
        if (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            check({test_name, " resp_valid"}, 128'(1'b1), 128'(resp_valid));
            check({test_name, " hit"}, 128'(exp.hit), 128'(resp.hit));
            // Line content only defined on a hit
            if (exp.hit) begin
                check({test_name, " line"}, exp.line, resp.line);
            end
        end else begin
            check({test_name, " resp_valid"}, 128'(1'b0), 128'(resp_valid));
        end
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #1;
        check_response();
        req_valid = 1'b0;
    endtask

    // Issue one request and step the model in request order
    task automatic drive_req(input op_e op, input logic [`ICACHE_ADDR_W-1:0] addr,
                             input line_t wdata, input be_t be);
        index_t idx;
        tag_t   tg;
        logic   hit;
        line_t  merged;
        @(posedge clk);
        #1;
        check_response();
        idx    = addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
        tg     = addr[`ICACHE_OFFSET_W + `ICACHE_INDEX_W +: `ICACHE_TAG_W];
        hit    = model_valid[idx] && (model_tag[idx] == tg);
        merged = model_line[idx];
        case (op)
            op_lookup: exp_q.push_back('{hit: hit, line: merged});
            op_store: begin
                // Miss leaves the line alone
                if (hit) begin
                    for (int i = 0; i < `ICACHE_LINE_BYTES; i++) begin
                        if (be[i]) begin
                            merged[i] = wdata[i];
                        end
                    end
                    model_line[idx] = merged;
                end
                exp_q.push_back('{hit: hit, line: merged});
            end
            op_refill: begin
                model_valid[idx] = 1'b1;
                model_tag[idx]   = tg;
                model_line[idx]  = wdata;
            end
            default: model_valid = '0;
        endcase
        req_valid = 1'b1;
        req       = '{op: op, addr: addr, wdata: wdata, be: be};
    endtask

    // Mixed ops, tags from a pool of four, idle gaps
    task automatic random_stream(input int count);
        logic [127:0] r;
        op_e          op;
        tag_t         tg;
        index_t       idx;
        line_t        wdata;
        be_t          be;
        for (int n = 0; n < count; n++) begin
            r = rand_bits(2);
            if (r[1:0] == 2'd0) begin
                drive_idle();
            end
            r = rand_bits(4);
            if (r[3:0] < 4'd6) begin
                op = op_lookup;
            end else if (r[3:0] < 4'd10) begin
                op = op_store;
            end else if (r[3:0] < 4'd15) begin
                op = op_refill;
            end else begin
                op = op_flush;
            end
            r     = rand_bits(2);
            tg    = {6'b101101, r[1:0]};
            r     = rand_bits(4);
            idx   = r[3:0];
            wdata = rand_bits(128);
            r     = rand_bits(16);
            be    = r[15:0];
            r     = rand_bits(4);
            drive_req(op, make_addr(tg, idx, r[3:0]), wdata, be);
        end
    endtask

    initial begin
        line_t line_a;
        line_t line_b;
        line_t line_c;
        arst_n      = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        model_valid = '0;
        line_a      = rand_bits(128);
        line_b      = rand_bits(128);
        line_c      = rand_bits(128);
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Everything misses out of reset
        test_name = "reset_miss";
        for (int i = 0; i < 4; i++) begin
            drive_req(op_lookup, make_addr(8'hB4, index_t'(i), 4'h0), '0, '0);
        end
        drive_idle();

        // Refill then hit, other tag at the same set misses
        test_name = "refill_hit";
        drive_req(op_refill, make_addr(8'hB4, 4'd3, 4'h0), line_a, '0);
        drive_idle();
        drive_idle();
        drive_req(op_lookup, make_addr(8'hB4, 4'd3, 4'h5), '0, '0);
        drive_req(op_lookup, make_addr(8'hB5, 4'd3, 4'h0), '0, '0);
        drive_idle();

        // Byte merge on a hit, no effect on a miss
        test_name = "store_merge";
        drive_req(op_store, make_addr(8'hB4, 4'd3, 4'h0), line_b, 16'h0F0F);
        drive_idle();
        drive_req(op_lookup, make_addr(8'hB4, 4'd3, 4'h0), '0, '0);
        drive_req(op_store, make_addr(8'hB5, 4'd3, 4'h0), line_c, '1);
        drive_idle();
        drive_req(op_lookup, make_addr(8'hB4, 4'd3, 4'h0), '0, '0);
        drive_idle();

        // Back to back, each sees the previous write via forwarding
        test_name = "forward";
        drive_req(op_refill, make_addr(8'hB6, 4'd7, 4'h0), line_a, '1);
        drive_req(op_lookup, make_addr(8'hB6, 4'd7, 4'h0), '0, '0);
        drive_req(op_store, make_addr(8'hB6, 4'd7, 4'h0), line_b, 16'h00FF);
        drive_req(op_store, make_addr(8'hB6, 4'd7, 4'h0), line_c, 16'hF0F0);
        drive_req(op_lookup, make_addr(8'hB6, 4'd7, 4'h0), '0, '0);
        drive_req(op_flush, '0, '0, '0);
        drive_req(op_lookup, make_addr(8'hB6, 4'd7, 4'h0), '0, '0);

        // Misses after a flush once the write has landed
        test_name = "flush_miss";
        drive_idle();
        drive_req(op_lookup, make_addr(8'hB4, 4'd3, 4'h0), '0, '0);
        drive_req(op_lookup, make_addr(8'hB6, 4'd7, 4'h0), '0, '0);
        drive_idle();

        test_name = "random";
        random_stream(num_random);
        drive_idle();
        drive_idle();

        // Assertion failures at the last edge are not yet seen by the watcher
        if (UUT.props.fail_count != 0) begin
            $display("A response timing assertion on the bank failed");
            $display("sim failed");
            $fatal(1, "assertion failure");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- icache_bank_props.sv
// Bound assertions on response timing of the cache bank
`timescale 1ns/1ps
`default_nettype none

module icache_bank_props (
    input logic              clk,
    input logic              arst_n,
    input logic              req_valid,
    input icache_pkg::req_t  req,
    input logic              resp_valid
);

    import icache_pkg::*;

    logic resp_op;

    // Count of failed assertions, watched by the testbench
    int   fail_count = 0;

    // Only lookup and store answer
    assign resp_op = req_valid && (req.op == op_lookup || req.op == op_store);

    a_resp_follows: assert property (@(posedge clk) disable iff (!arst_n)
        resp_op |=> resp_valid)
        else begin
            fail_count = fail_count + 1;
            $error("resp_valid missing one cycle after a lookup or store");
        end

    a_resp_only_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        !resp_op |=> !resp_valid)
        else begin
            fail_count = fail_count + 1;
            $error("resp_valid high with no lookup or store the cycle before");
        end

    a_resp_low_in_reset: assert property (@(posedge clk)
        !arst_n |-> !resp_valid)
        else begin
            fail_count = fail_count + 1;
            $error("resp_valid high during reset");
        end

endmodule

bind icache_bank icache_bank_props props (
    .clk        ( clk        ),
    .arst_n     ( arst_n     ),
    .req_valid  ( req_valid  ),
    .req        ( req        ),
    .resp_valid ( resp_valid )
);

`default_nettype wire

//--- icache_bank.sv
// Cache bank top connecting controller, tag store and line data store
`timescale 1ns/1ps
`default_nettype none

module icache_bank (
    input  logic               clk,
    input  logic               arst_n,

    input  logic               req_valid,
    input  icache_pkg::req_t   req,

    output logic               resp_valid,
    output icache_pkg::resp_t  resp
);

    import icache_pkg::*;

    // Read side
    logic       tag_rd_en;
    logic       data_rd_en;
    index_t     rd_index;
    tag_entry_t tag_entry;
    line_t      data_line;

    // Write side
    logic       tag_wr_en;
    tag_t       tag_wr;
    logic       data_wr_en;
    line_t      data_wr;
    be_t        data_be;
    index_t     wr_index;
    logic       flush_clear;

    icache_ctrl ctrl (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .req_valid   ( req_valid   ),
        .req         ( req         ),
        .tag_rd_en   ( tag_rd_en   ),
        .data_rd_en  ( data_rd_en  ),
        .rd_index    ( rd_index    ),
        .tag_entry   ( tag_entry   ),
        .data_line   ( data_line   ),
        .tag_wr_en   ( tag_wr_en   ),
        .tag_wr      ( tag_wr      ),
        .data_wr_en  ( data_wr_en  ),
        .data_wr     ( data_wr     ),
        .data_be     ( data_be     ),
        .wr_index    ( wr_index    ),
        .flush_clear ( flush_clear ),
        .resp_valid  ( resp_valid  ),
        .resp        ( resp        )
    );

    icache_tag_ram tag_ram (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .read_en     ( tag_rd_en   ),
        .read_addr   ( rd_index    ),
        .entry       ( tag_entry   ),
        .write_en    ( tag_wr_en   ),
        .write_addr  ( wr_index    ),
        .tag         ( tag_wr      ),
        .flush_clear ( flush_clear )
    );

    ram_ws_rs_data_scm data_ram (
        .clk        ( clk        ),
        .read_en    ( data_rd_en ),
        .read_addr  ( rd_index   ),
        .rdata      ( data_line  ),
        .write_en   ( data_wr_en ),
        .write_addr ( wr_index   ),
        .wdata      ( data_wr    ),
        .be         ( data_be    )
    );

endmodule

`default_nettype wire

//--- icache_ctrl.sv
// Stage-1 register, write forwarding, hit compare, write generation and response
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_ctrl (
    input  logic                     clk,
    input  logic                     arst_n,

    // Request port
    input  logic                     req_valid,
    input  icache_pkg::req_t         req,

    // Stage 0 reads
    output logic                     tag_rd_en,
    output logic                     data_rd_en,
    output icache_pkg::index_t       rd_index,

    // Stage 1 read results
    input  icache_pkg::tag_entry_t   tag_entry,
    input  icache_pkg::line_t        data_line,

    // Stage 1 writes
    output logic                     tag_wr_en,
    output icache_pkg::tag_t         tag_wr,
    output logic                     data_wr_en,
    output icache_pkg::line_t        data_wr,
    output icache_pkg::be_t          data_be,
    output icache_pkg::index_t       wr_index,
    output logic                     flush_clear,

    // Response port
    output logic                     resp_valid,
    output icache_pkg::resp_t        resp
);

    import icache_pkg::*;

    // Payload of the write issued last cycle
    typedef struct packed {
        index_t index;
        tag_t   tag;
        line_t  line;
        be_t    be;
    } wr_rec_t;

    localparam int unsigned idx_lo = `ICACHE_OFFSET_W;
    localparam int unsigned tag_lo = `ICACHE_OFFSET_W + `ICACHE_INDEX_W;

    logic       s1_valid_q;
    req_t       s1_req_q;
    index_t     s1_index;
    tag_t       s1_tag;

    logic       last_tag_wr_q;
    logic       last_data_wr_q;
    logic       last_flush_q;
    wr_rec_t    last_q;
    logic       same_index;

    tag_entry_t entry_m;
    line_t      line_m;
    logic       hit;

    // Stage 0, reads go out with the request index
    assign tag_rd_en  = req_valid;
    assign data_rd_en = req_valid;
    assign rd_index   = req.addr[idx_lo +: `ICACHE_INDEX_W];

    // Stage 1 register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            s1_req_q <= req;
        end
    end

    assign s1_index = s1_req_q.addr[idx_lo +: `ICACHE_INDEX_W];
    assign s1_tag   = s1_req_q.addr[tag_lo +: `ICACHE_TAG_W];

    // Record of last cycle's write, missed by this request's read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_tag_wr_q  <= 1'b0;
            last_data_wr_q <= 1'b0;
            last_flush_q   <= 1'b0;
        end else begin
            last_tag_wr_q  <= tag_wr_en;
            last_data_wr_q <= data_wr_en;
            last_flush_q   <= flush_clear;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_wr_en || data_wr_en) begin
            last_q <= '{index: wr_index, tag: tag_wr, line: data_wr, be: data_be};
        end
    end

    assign same_index = (last_q.index == s1_index);

    // Forward the recorded write onto the read results
    always_comb begin
        entry_m = tag_entry;
        line_m  = data_line;
        // Flush hits every index
        if (last_flush_q) begin
            entry_m.valid = 1'b0;
        end
        if (last_tag_wr_q && same_index) begin
            entry_m.valid = 1'b1;
            entry_m.tag   = last_q.tag;
        end
        for (int i = 0; i < `ICACHE_LINE_BYTES; i++) begin
            if (last_data_wr_q && same_index && last_q.be[i]) begin
                line_m[i] = last_q.line[i];
            end
        end
    end

    assign hit = entry_m.valid && (entry_m.tag == s1_tag);

    // At most one write per request
    always_comb begin
        tag_wr_en   = 1'b0;
        data_wr_en  = 1'b0;
        flush_clear = 1'b0;
        tag_wr      = s1_tag;
        wr_index    = s1_index;
        data_wr     = s1_req_q.wdata;
        data_be     = s1_req_q.be;
        if (s1_valid_q) begin
            unique case (s1_req_q.op)
                op_refill: begin
                    tag_wr_en  = 1'b1;
                    data_wr_en = 1'b1;
                    data_be    = '1;
                end
                // Store only on a hit
                op_store:  data_wr_en  = hit;
                op_flush:  flush_clear = 1'b1;
                default:   ;
            endcase
        end
    end

    // Response for lookup and store only
    assign resp_valid = s1_valid_q &&
                        (s1_req_q.op == op_lookup || s1_req_q.op == op_store);

    // Store hit reports the line after the merge
    always_comb begin
        resp.hit  = hit;
        resp.line = line_m;
        if (s1_req_q.op == op_store && hit) begin
            for (int i = 0; i < `ICACHE_LINE_BYTES; i++) begin
                if (s1_req_q.be[i]) begin
                    resp.line[i] = s1_req_q.wdata[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- icache_tag_ram.sv
// Tag store with valid-bit vector, asynchronous reset and one-cycle flush clear
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_tag_ram (
    input  logic                     clk,
    input  logic                     arst_n,

    // Read port
    input  logic                     read_en,
    input  icache_pkg::index_t       read_addr,
    output icache_pkg::tag_entry_t   entry,

    // Write port, a write also marks the set valid
    input  logic                     write_en,
    input  icache_pkg::index_t       write_addr,
    input  icache_pkg::tag_t         tag,

    // Clears every valid bit at the next edge
    input  logic                     flush_clear
);

    import icache_pkg::*;

    logic [`ICACHE_SETS-1:0] valid_q;
    logic                    valid_rd_q;
    tag_t                    tag_rd;

    // Tag payload
    register_file_1r_1w #(
        .payload_t ( tag_t        ),
        .depth     ( `ICACHE_SETS )
    ) scm_tag (
        .clk        ( clk        ),
        .write_en   ( write_en   ),
        .write_addr ( write_addr ),
        .write_data ( tag        ),
        .read_en    ( read_en    ),
        .read_addr  ( read_addr  ),
        .read_data  ( tag_rd     )
    );

    // Valid vector
    // Write set comes last so it beats a same-cycle flush
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else begin
            if (flush_clear) begin
                valid_q <= '0;
            end
            if (write_en) begin
                valid_q[write_addr] <= 1'b1;
            end
        end
    end

    // Valid read registered next to the tag read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_rd_q <= 1'b0;
        end else if (read_en) begin
            valid_rd_q <= valid_q[read_addr];
        end
    end

    assign entry = '{valid: valid_rd_q, tag: tag_rd};

endmodule

`default_nettype wire

//--- ram_ws_rs_data_scm.sv
// Line data store of per-byte register-file lanes with byte-enabled writes
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module ram_ws_rs_data_scm (
    input  logic                clk,

    // Read port
    input  logic                read_en,
    input  icache_pkg::index_t  read_addr,
    output icache_pkg::line_t   rdata,

    // Write port
    input  logic                write_en,
    input  icache_pkg::index_t  write_addr,
    input  icache_pkg::line_t   wdata,
    input  icache_pkg::be_t     be
);

    import icache_pkg::*;

    // One lane per line byte
    // Each lane gated by its own enable bit
    for (genvar i = 0; i < `ICACHE_LINE_BYTES; i++) begin : g_lane
        register_file_1r_1w #(
            .payload_t ( byte_t       ),
            .depth     ( `ICACHE_SETS )
        ) scm_lane (
            .clk        ( clk                ),

            .write_en   ( write_en & be[i]   ),
            .write_addr ( write_addr         ),
            .write_data ( wdata[i]           ),

            // Lane outputs concatenate into the full line
            .read_en    ( read_en            ),
            .read_addr  ( read_addr          ),
            .read_data  ( rdata[i]           )
        );
    end

endmodule

`default_nettype wire

//--- register_file_1r_1w.sv
// Generic one-read one-write flop array with registered read port
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module register_file_1r_1w #(
    parameter type         payload_t = icache_pkg::byte_t,
    parameter int unsigned depth     = `ICACHE_SETS
) (
    input  logic                clk,

    // Write port
    input  logic                write_en,
    input  icache_pkg::index_t  write_addr,
    input  payload_t            write_data,

    // Read port
    input  logic                read_en,
    input  icache_pkg::index_t  read_addr,
    output payload_t            read_data
);

    // Storage, no reset
    payload_t mem [depth];

    // Write lands at the clock edge
    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
    end

    // Registered read, same-cycle write to the same address gives old data
    // Output holds while read_en is low
    always_ff @(posedge clk) begin
        if (read_en) begin
            read_data <= mem[read_addr];
        end
    end

endmodule

`default_nettype wire

//--- icache_pkg.sv
// Operation enum, request, response and tag-entry structs, byte and line types
`default_nettype none

`include "icache_macros.svh"

package icache_pkg;

    // Data granules
    typedef logic [7:0] byte_t;
    typedef byte_t [`ICACHE_LINE_BYTES-1:0] line_t;
    typedef logic [`ICACHE_LINE_BYTES-1:0] be_t;

    // Address fields
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;
    typedef logic [`ICACHE_TAG_W-1:0] tag_t;

    // Request kinds on the single port
    typedef enum logic [1:0] {
        op_lookup = 2'd0,
        op_store  = 2'd1,
        op_refill = 2'd2,
        op_flush  = 2'd3
    } op_e;

    // One tag-store entry
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // Incoming request, wdata and be only matter for store and refill
    typedef struct packed {
        op_e                       op;
        logic [`ICACHE_ADDR_W-1:0] addr;
        line_t                     wdata;
        be_t                       be;
    } req_t;

    // Response to lookup and store
    typedef struct packed {
        logic  hit;
        line_t line;
    } resp_t;

endpackage

`default_nettype wire

//--- icache_macros.svh
// Address split and line geometry constants for the instruction-cache bank
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// Byte address seen at the request port
`define ICACHE_ADDR_W 16

// Byte offset inside one line
`define ICACHE_OFFSET_W 4

// Set index and tag, tag takes the upper bits
`define ICACHE_INDEX_W 4
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

// Geometry derived from the split
`define ICACHE_SETS (1 << `ICACHE_INDEX_W)
`define ICACHE_LINE_BYTES (1 << `ICACHE_OFFSET_W)

`endif
